// ==== source/bdPkg.sv ====
package bdPkg;

  ////////////////////
  // word geometry

  // funnel output word as it leaves the chip
  localparam int NBdData = 34;
  // widest leaf payload, route bits stripped
  localparam int NPayload = 32;
  // leaves of the output funnel
  localparam int NLeaf = 13;
  localparam int NLeafCode = 4;

  ////////////////////
  // leaf codes

  // code order follows the route table below
  localparam logic [NLeafCode-1:0] LeafDumpAm = 4'd0;
  localparam logic [NLeafCode-1:0] LeafDumpMm = 4'd1;
  localparam logic [NLeafCode-1:0] LeafDumpPat = 4'd2;
  localparam logic [NLeafCode-1:0] LeafDumpPostFifo0 = 4'd3;
  localparam logic [NLeafCode-1:0] LeafDumpPostFifo1 = 4'd4;
  localparam logic [NLeafCode-1:0] LeafDumpPreFifo = 4'd5;
  localparam logic [NLeafCode-1:0] LeafDumpTat0 = 4'd6;
  localparam logic [NLeafCode-1:0] LeafDumpTat1 = 4'd7;
  localparam logic [NLeafCode-1:0] LeafNrni = 4'd8;
  localparam logic [NLeafCode-1:0] LeafOvflw0 = 4'd9;
  localparam logic [NLeafCode-1:0] LeafOvflw1 = 4'd10;
  localparam logic [NLeafCode-1:0] LeafRoAcc = 4'd11;
  localparam logic [NLeafCode-1:0] LeafRoTat = 4'd12;
  // no route matched, unreachable with a complete table
  localparam logic [NLeafCode-1:0] LeafInvalid = 4'd13;

  ////////////////////
  // route table

  // prefixes sit in the top bits of the word
  localparam logic [0:NLeaf-1][NBdData-1:0] RouteBits = '{
    {6'b101000, {(NBdData-6){1'b0}}},
    {6'b101001, {(NBdData-6){1'b0}}},
    {5'b10101, {(NBdData-5){1'b0}}},
    {6'b101110, {(NBdData-6){1'b0}}},
    {6'b101111, {(NBdData-6){1'b0}}},
    {6'b101101, {(NBdData-6){1'b0}}},
    {4'b1000, {(NBdData-4){1'b0}}},
    {4'b1001, {(NBdData-4){1'b0}}},
    {2'b11, {(NBdData-2){1'b0}}},
    {7'b1011000, {(NBdData-7){1'b0}}},
    {7'b1011001, {(NBdData-7){1'b0}}},
    {2'b01, {(NBdData-2){1'b0}}},
    {2'b00, {(NBdData-2){1'b0}}}
  };

  // prefix length per leaf, same order
  localparam logic [0:NLeaf-1][2:0] RouteLen = '{
    3'd6, 3'd6, 3'd5, 3'd6, 3'd6, 3'd6, 3'd4,
    3'd4, 3'd2, 3'd7, 3'd7, 3'd2, 3'd2
  };

  ////////////////////
  // buffering and stats

  // decoded words held ahead of the consumer
  localparam int OutFifoDepth = 4;
  // per-leaf word counter width, wraps
  localparam int NCount = 16;

endpackage

// ==== source/bdRouteDecoder.sv ====
`timescale 1ns/10ps

module bdRouteDecoder (
  input  logic                         clk,
  input  logic [bdPkg::NBdData-1:0]    word,
  output logic [bdPkg::NLeafCode-1:0]  leaf,
  output logic [bdPkg::NPayload-1:0]   payload
);

  import bdPkg::*;

  // one mask per leaf, ones over its prefix
  logic [NLeaf-1:0][NBdData-1:0] routeMask;
  // raw match per leaf
  logic [NLeaf-1:0] match;
  // prefix bits of the winning leaf
  logic [NBdData-1:0] prefixMask;
  logic [NBdData-1:0] maskedWord;

  ////////////////////
  // parallel match

  for (genvar i = 0; i < NLeaf; i++) begin : gRoute
    // top RouteLen bits set
    assign routeMask[i] = ~({NBdData{1'b1}} >> RouteLen[i]);
    assign match[i] = ((word & routeMask[i]) == RouteBits[i]);
  end

  ////////////////////
  // priority encode

  // table order, first hit wins
  always_comb begin
    if (match[0])
      leaf = LeafDumpAm;
    else if (match[1])
      leaf = LeafDumpMm;
    else if (match[2])
      leaf = LeafDumpPat;
    else if (match[3])
      leaf = LeafDumpPostFifo0;
    else if (match[4])
      leaf = LeafDumpPostFifo1;
    else if (match[5])
      leaf = LeafDumpPreFifo;
    else if (match[6])
      leaf = LeafDumpTat0;
    else if (match[7])
      leaf = LeafDumpTat1;
    else if (match[8])
      leaf = LeafNrni;
    else if (match[9])
      leaf = LeafOvflw0;
    else if (match[10])
      leaf = LeafOvflw1;
    else if (match[11])
      leaf = LeafRoAcc;
    else if (match[12])
      leaf = LeafRoTat;
    else
      leaf = LeafInvalid;
  end

  ////////////////////
  // payload strip

  // invalid leaf keeps every bit
  assign prefixMask = (leaf < NLeaf) ? routeMask[leaf] : '0;
  assign maskedWord = word & ~prefixMask;
  // route sits above bit 31 or is cleared here
  assign payload = maskedWord[NPayload-1:0];

  // prefix-free table, every defined word lands on exactly one leaf
  assert property (@(posedge clk)
    !$isunknown(word) |-> $onehot0(match) && (leaf != LeafInvalid))
    else $error("route decode of %h is ambiguous or invalid", word);

endmodule

// ==== source/bdDecodeStage.sv ====
`timescale 1ns/10ps

module bdDecodeStage (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         bdValid,
  input  logic [bdPkg::NBdData-1:0]    bdData,
  output logic                         bdReady,
  input  logic                         fifoFull,
  output logic                         stageValid,
  output logic [bdPkg::NLeafCode-1:0]  stageLeaf,
  output logic [bdPkg::NPayload-1:0]   stagePayload,
  output logic                         leafStrobe
);

  import bdPkg::*;

  // decoder result for the word on the input
  logic [NLeafCode-1:0] wordLeaf;
  logic [NPayload-1:0] wordPayload;
  // held word goes to the FIFO this cycle
  logic handOff;
  // new word captured this cycle
  logic load;

  ////////////////////
  // combinational decode

  // sits in front of the register, no extra cycle
  bdRouteDecoder i_bdRouteDecoder (
    .clk     (clk),
    .word    (bdData),
    .leaf    (wordLeaf),
    .payload (wordPayload)
  );

  ////////////////////
  // slice control

  assign handOff = stageValid && !fifoFull;
  // empty or emptying, so a full-rate stream has no bubbles
  assign bdReady = !stageValid || handOff;
  assign load = bdValid && bdReady;
  // one pulse per released word, also the FIFO push
  assign leafStrobe = handOff;

  always_ff @(posedge clk) begin
    if (reset) begin
      stageValid <= 1'b0;
    end else if (load) begin
      // refill wins over drain in the same cycle
      stageValid <= 1'b1;
    end else if (handOff) begin
      stageValid <= 1'b0;
    end
  end

  // payload register
  always_ff @(posedge clk) begin
    if (load) begin
      stageLeaf <= wordLeaf;
      stagePayload <= wordPayload;
    end
  end

  // a stalled entry must reach the FIFO unchanged
  assert property (@(posedge clk) disable iff (reset)
    stageValid && fifoFull |=>
      stageValid && $stable(stageLeaf) && $stable(stagePayload))
    else $error("stage entry changed while stalled");

endmodule

// ==== source/bdOutputFifo.sv ====
`timescale 1ns/10ps

module bdOutputFifo #(
  parameter int depth = bdPkg::OutFifoDepth
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         push,
  input  logic [bdPkg::NLeafCode-1:0]  pushLeaf,
  input  logic [bdPkg::NPayload-1:0]   pushPayload,
  output logic                         full,
  output logic                         decValid,
  output logic [bdPkg::NLeafCode-1:0]  decLeaf,
  output logic [bdPkg::NPayload-1:0]   decPayload,
  input  logic                         decReady
);

  import bdPkg::*;

  // address bits, depth is a power of two
  localparam int NAddr = $clog2(depth);

  // storage, leaf and payload side by side
  logic [NLeafCode-1:0] leafMem [depth];
  logic [NPayload-1:0] payloadMem [depth];
  // extra top bit tells full from empty
  logic [NAddr:0] wrPtr;
  logic [NAddr:0] rdPtr;
  logic empty;
  logic pop;

  ////////////////////
  // flags

  assign empty = (wrPtr == rdPtr);
  // same slot, one lap apart
  assign full = (wrPtr[NAddr] != rdPtr[NAddr]) &&
                (wrPtr[NAddr-1:0] == rdPtr[NAddr-1:0]);
  assign decValid = !empty;
  assign pop = decValid && decReady;

  ////////////////////
  // pointers

  // push and pop are independent, both may fire together
  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (push)
        wrPtr <= wrPtr + 1'b1;
      if (pop)
        rdPtr <= rdPtr + 1'b1;
    end
  end

  ////////////////////
  // storage

  always_ff @(posedge clk) begin
    if (push) begin
      leafMem[wrPtr[NAddr-1:0]] <= pushLeaf;
      payloadMem[wrPtr[NAddr-1:0]] <= pushPayload;
    end
  end

  // show-ahead, head entry always on the outputs
  assign decLeaf = leafMem[rdPtr[NAddr-1:0]];
  assign decPayload = payloadMem[rdPtr[NAddr-1:0]];

  // upstream stage has to respect full
  assert property (@(posedge clk) disable iff (reset) !(push && full))
    else $error("push into a full output FIFO");

  // consumer sees a defined valid once reset is gone
  assert property (@(posedge clk) !reset |-> !$isunknown(decValid))
    else $error("decValid unknown after reset");

endmodule

// ==== source/bdLeafCounters.sv ====
`timescale 1ns/10ps

module bdLeafCounters (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         leafStrobe,
  input  logic [bdPkg::NLeafCode-1:0]  leaf,
  input  logic [bdPkg::NLeafCode-1:0]  statLeaf,
  output logic [bdPkg::NCount-1:0]     statCount
);

  import bdPkg::*;

  // one counter per funnel leaf
  logic [NCount-1:0] count [NLeaf];
  // per-leaf increment enable
  logic [NLeaf-1:0] hit;

  ////////////////////
  // counters

  for (genvar i = 0; i < NLeaf; i++) begin : gCount
    assign hit[i] = leafStrobe && (leaf == i);

    // free-running, wraps past all ones
    always_ff @(posedge clk) begin
      if (reset) begin
        count[i] <= '0;
      end else if (hit[i]) begin
        count[i] <= count[i] + 1'b1;
      end
    end
  end

  ////////////////////
  // status read

  // same-cycle read
  // codes past the last leaf read as zero
  assign statCount = (statLeaf < NLeaf) ? count[statLeaf] : '0;

endmodule

// ==== source/bdDecodeTop.sv ====
`timescale 1ns/10ps

module bdDecodeTop (
  input  logic                         clk,
  input  logic                         reset,
  // funnel side
  input  logic                         bdValid,
  input  logic [bdPkg::NBdData-1:0]    bdData,
  output logic                         bdReady,
  // consumer side
  output logic                         decValid,
  output logic [bdPkg::NLeafCode-1:0]  decLeaf,
  output logic [bdPkg::NPayload-1:0]   decPayload,
  input  logic                         decReady,
  // per-leaf word counts
  input  logic [bdPkg::NLeafCode-1:0]  statLeaf,
  output logic [bdPkg::NCount-1:0]     statCount
);

  import bdPkg::*;

  ////////////////////
  // stage to FIFO

  logic [NLeafCode-1:0] stageLeaf;
  logic [NPayload-1:0] stagePayload;
  // release strobe, push and count in one
  logic leafStrobe;
  logic fifoFull;

  // stageValid stays inside, the strobe already carries it
  bdDecodeStage i_bdDecodeStage (
    .clk          (clk),
    .reset        (reset),
    .bdValid      (bdValid),
    .bdData       (bdData),
    .bdReady      (bdReady),
    .fifoFull     (fifoFull),
    .stageValid   (),
    .stageLeaf    (stageLeaf),
    .stagePayload (stagePayload),
    .leafStrobe   (leafStrobe)
  );

  bdOutputFifo #(
    .depth (OutFifoDepth)
  ) i_bdOutputFifo (
    .clk         (clk),
    .reset       (reset),
    .push        (leafStrobe),
    .pushLeaf    (stageLeaf),
    .pushPayload (stagePayload),
    .full        (fifoFull),
    .decValid    (decValid),
    .decLeaf     (decLeaf),
    .decPayload  (decPayload),
    .decReady    (decReady)
  );

  // counts on the push edge
  bdLeafCounters i_bdLeafCounters (
    .clk        (clk),
    .reset      (reset),
    .leafStrobe (leafStrobe),
    .leaf       (stageLeaf),
    .statLeaf   (statLeaf),
    .statCount  (statCount)
  );

endmodule

// ==== verif/bdDecodeTb.sv ====
`timescale 1ns/10ps

module bdDecodeTb;

  import bdPkg::*;

  localparam logic [31:0] Seed = 32'h64ff_1b22;
  localparam int RandomWords = 400;
  // per-wait cycle limits
  localparam int WaitLimit = 100;
  localparam int DrainLimit = 4000;

  logic clk = 1'b0;
  logic reset;
  logic bdValid;
  logic [NBdData-1:0] bdData;
  logic bdReady;
  logic decValid;
  logic [NLeafCode-1:0] decLeaf;
  logic [NPayload-1:0] decPayload;
  logic decReady;
  logic [NLeafCode-1:0] statLeaf;
  logic [NCount-1:0] statCount;

  // consumer throttling on or off
  logic backPressure = 1'b0;

  ////////////////////
  // reference route table

  // prefixes right-aligned in leaf code order
  int refPrefix[NLeaf] = '{'b101000, 'b101001, 'b10101, 'b101110, 'b101111, 'b101101,
                           'b1000, 'b1001, 'b11, 'b1011000, 'b1011001, 'b01, 'b00};
  int refLen[NLeaf] = '{6, 6, 5, 6, 6, 6, 4, 4, 2, 7, 7, 2, 2};

  // model state
  logic [NLeafCode-1:0] expLeafQ[$];
  logic [NPayload-1:0] expPayloadQ[$];
  logic [NCount-1:0] expCount[NLeaf];
  int inCount = 0;
  int outCount = 0;

  // error tallies per kind
  int leafErrors = 0;
  int payloadErrors = 0;
  int countErrors = 0;
  int flagErrors = 0;
  int otherErrors = 0;

  bdDecodeTop i_dut (
    .clk        (clk),
    .reset      (reset),
    .bdValid    (bdValid),
    .bdData     (bdData),
    .bdReady    (bdReady),
    .decValid   (decValid),
    .decLeaf    (decLeaf),
    .decPayload (decPayload),
    .decReady   (decReady),
    .statLeaf   (statLeaf),
    .statCount  (statCount)
  );

  always #4 clk = ~clk;

  ////////////////////
  // model and stimulus helpers

  // first table entry whose prefix matches or NLeaf if none
  function automatic int refLeaf(input logic [NBdData-1:0] w);
    int hit;
    hit = NLeaf;
    for (int i = 0; i < NLeaf; i++) begin
      if (hit == NLeaf && (w >> (NBdData - refLen[i])) == refPrefix[i])
        hit = i;
    end
    return hit;
  endfunction

  // route bits cleared and low word kept
  function automatic logic [NPayload-1:0] refPayload(input logic [NBdData-1:0] w,
                                                     input int leaf);
    logic [NBdData-1:0] masked;
    masked = w;
    if (leaf < NLeaf)
      masked = w & ({NBdData{1'b1}} >> refLen[leaf]);
    return masked[NPayload-1:0];
  endfunction

  function automatic logic [NBdData-1:0] applyPrefix(input logic [NBdData-1:0] w,
                                                     input int leaf);
    logic [NBdData-1:0] keep;
    logic [NBdData-1:0] pre;
    keep = {NBdData{1'b1}} >> refLen[leaf];
    pre = refPrefix[leaf];
    return (w & keep) | (pre << (NBdData - refLen[leaf]));
  endfunction

  // uniform leaf with random fill
  function automatic logic [NBdData-1:0] randomWord();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return applyPrefix(r[NBdData-1:0], $urandom_range(NLeaf - 1));
  endfunction

  ////////////////////
  // compare tasks

  task automatic checkLeaf(input logic [NLeafCode-1:0] got, input logic [NLeafCode-1:0] exp,
                           input string what);
    if (got !== exp) begin
      leafErrors++;
      $display("[FAIL] %0t ns: %s leaf %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic checkPayload(input logic [NPayload-1:0] got, input logic [NPayload-1:0] exp,
                              input string what);
    if (got !== exp) begin
      payloadErrors++;
      $display("[FAIL] %0t ns: %s payload %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkCount(input logic [NCount-1:0] got, input logic [NCount-1:0] exp,
                            input string what);
    if (got !== exp) begin
      countErrors++;
      $display("[FAIL] %0t ns: %s count %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic checkFlag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flagErrors++;
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////
  // driving

  // entered on a rising edge and returns on the transfer edge
  task automatic sendWord(input logic [NBdData-1:0] w);
    int waited;
    bdValid <= 1'b1;
    bdData <= w;
    waited = 0;
    @(negedge clk);
    while (!bdReady && waited < WaitLimit) begin
      @(negedge clk);
      waited++;
    end
    if (!bdReady) begin
      otherErrors++;
      $display("input was never accepted within %0d cycles", WaitLimit);
    end
    @(posedge clk);
    bdValid <= 1'b0;
  endtask

  // all accepted words out and nothing left in the FIFO
  task automatic waitDrain();
    int waited;
    waited = 0;
    @(negedge clk);
    while ((expLeafQ.size() != 0 || decValid) && waited < DrainLimit) begin
      @(negedge clk);
      waited++;
    end
    if (expLeafQ.size() != 0 || decValid) begin
      otherErrors++;
      $display("output did not drain within %0d cycles, %0d words missing",
               DrainLimit, expLeafQ.size());
    end
  endtask

  // leaf counters read in the same cycle
  task automatic checkStatus(input int first, input int last, input string what);
    for (int i = first; i <= last; i++) begin
      @(posedge clk);
      statLeaf <= i;
      @(negedge clk);
      checkCount(statCount, (i < NLeaf) ? expCount[i] : '0, $sformatf("%s leaf %0d", what, i));
    end
  endtask

  // consumer about 40 % idle when throttled
  always @(posedge clk) begin
    if (backPressure)
      decReady <= ($urandom_range(99) >= 40);
    else
      decReady <= 1'b1;
  end

  ////////////////////
  // monitor

  // sampled mid-cycle where each flag pair marks a transfer at the next edge
  always @(negedge clk) begin : monitor
    int mLeaf;
    logic [NLeafCode-1:0] headLeaf;
    logic [NPayload-1:0] headPayload;
    if (!reset) begin
      if (decValid && decReady) begin
        if (expLeafQ.size() == 0) begin
          otherErrors++;
          $display("output word at %0t ns with no input word outstanding", $time);
        end else begin
          headLeaf = expLeafQ.pop_front();
          headPayload = expPayloadQ.pop_front();
          checkLeaf(decLeaf, headLeaf, "output");
          checkPayload(decPayload, headPayload, "output");
        end
        // every output transfer, expected or not
        outCount++;
      end
      if (bdValid && bdReady) begin
        mLeaf = refLeaf(bdData);
        expLeafQ.push_back(mLeaf[NLeafCode-1:0]);
        expPayloadQ.push_back(refPayload(bdData, mLeaf));
        if (mLeaf < NLeaf)
          expCount[mLeaf]++;
        inCount++;
      end
    end
  end

  ////////////////////
  // main sequence

  initial begin
    int waited;
    int latency;
    logic seen;
    void'($urandom(Seed));
    reset = 1'b1;
    bdValid = 1'b0;
    bdData = '0;
    decReady = 1'b1;
    statLeaf = '0;
    for (int i = 0; i < NLeaf; i++)
      expCount[i] = '0;

    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // idle state after reset
    waited = 0;
    @(negedge clk);
    while (reset && waited < WaitLimit) begin
      @(negedge clk);
      waited++;
    end
    if (reset) begin
      otherErrors++;
      $display("reset did not release within %0d cycles", WaitLimit);
    end
    checkFlag(decValid, 1'b0, "decValid after reset");
    checkFlag(bdReady, 1'b1, "bdReady after reset");
    checkStatus(0, NLeaf - 1, "after reset");

    // every prefix length with fill of all zeros then all ones
    @(posedge clk);
    backPressure <= 1'b1;
    for (int i = 0; i < NLeaf; i++) begin
      for (int f = 0; f < 2; f++) begin
        sendWord(applyPrefix({NBdData{f[0]}}, i));
      end
    end

    // random stream with random gaps
    for (int n = 0; n < RandomWords; n++) begin
      if ($urandom_range(99) < 30) begin
        bdValid <= 1'b0;
        @(posedge clk);
      end else begin
        sendWord(randomWord());
      end
    end
    backPressure <= 1'b0;
    waitDrain();
    if (outCount != inCount) begin
      otherErrors++;
      $display("[FAIL] %0t ns: %0d words out, %0d words in", $time, outCount, inCount);
    end

    // single word through an empty pipeline
    @(posedge clk);
    bdValid <= 1'b1;
    bdData <= randomWord();
    @(negedge clk);
    checkFlag(bdReady, 1'b1, "bdReady before latency word");
    @(posedge clk);
    bdValid <= 1'b0;
    // edges counted from the transfer edge up to the one raising decValid
    latency = 1;
    seen = 1'b0;
    while (!seen && latency < WaitLimit) begin
      @(negedge clk);
      if (decValid) begin
        seen = 1'b1;
      end else begin
        @(posedge clk);
        latency++;
      end
    end
    if (!seen) begin
      otherErrors++;
      $display("latency word never appeared within %0d cycles", WaitLimit);
    end else if (latency != 2) begin
      otherErrors++;
      $display("[FAIL] %0t ns: latency %0d cycles, expected 2", $time, latency);
    end
    waitDrain();

    // counters against the model with out-of-range codes at zero
    checkStatus(0, 15, "after drain");

    $display("errors: leaf %0d, payload %0d, count %0d, flag %0d, other %0d",
             leafErrors, payloadErrors, countErrors, flagErrors, otherErrors);
    if (leafErrors + payloadErrors + countErrors + flagErrors + otherErrors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== build.f ====
source/bdPkg.sv
source/bdRouteDecoder.sv
source/bdDecodeStage.sv
source/bdOutputFifo.sv
source/bdLeafCounters.sv
source/bdDecodeTop.sv
verif/bdDecodeTb.sv

// ==== Bender.yml ====
package:
  name: bd_decode

sources:
  # package first, then leaf modules, then the top level
  - source/bdPkg.sv
  - source/bdRouteDecoder.sv
  - source/bdDecodeStage.sv
  - source/bdOutputFifo.sv
  - source/bdLeafCounters.sv
  - source/bdDecodeTop.sv

  - target: test
    files:
      - verif/bdDecodeTb.sv
